// ==== sources.f ====
logic/uart_cmd_pkg.sv
logic/uart_tx_frame.sv
logic/uart_rx_frame.sv
logic/uart_cmd_sequencer.sv
logic/uart_apb_regs.sv
logic/uart_cmd_top.sv
test/uart_device_model.sv
test/tb_uart_cmd.sv

// ==== Makefile ====
TOOL     ?= verilator
FLAGS    ?= --timing
TOP      ?= tb_uart_cmd
FILELIST ?= sources.f
OBJ_DIR  ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# the binary exits non-zero on $$fatal
sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== test/tb_uart_cmd.sv ====
`timescale 1ns/100ps

module tb_uart_cmd import uart_cmd_pkg::*;
();

  localparam int baud_div = 16;
  localparam int n_cmds   = 12;   // at least the commands issued below
  localparam int watchdog_cycles = 2 * n_cmds * (22 + 15 + 255) * baud_div + 4000;

  localparam apb_rsp_s rsp_ok  = '{prdata: 32'd0, pready: 1'b1, pslverr: 1'b0};
  localparam apb_rsp_s rsp_err = '{prdata: 32'd0, pready: 1'b1, pslverr: 1'b1};

  logic        clk;
  logic        rst_n;
  apb_req_s    apb_req;
  apb_rsp_s    apb_rsp;
  logic        tx;
  logic        rx;
  logic        bad_parity;
  logic        silent;
  logic [15:0] lfsr_state;

  uart_cmd_top #(.baud_div(baud_div)) dut0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .rx      (rx),
    .tx      (tx)
  );

  uart_device_model #(.baud_div(baud_div)) dev0 (
    .clk        (clk),
    .tx         (tx),
    .bad_parity (bad_parity),
    .silent     (silent),
    .rx         (rx)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [7:0] model_reply(input logic [6:0] addr);
    return {1'b0, addr} ^ 8'h5A;
  endfunction

  function automatic uart_status_s exp_status(input logic rdv, input logic perr,
                                              input logic tmo);
    return '{timeout: tmo, parity_err: perr, rd_valid: rdv, busy: 1'b0};
  endfunction

  // galois form, taps 16,14,13,11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [15:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[14:0], lfsr_state[0]};
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic value_fail(input string name, input string exp, input string act);
    abort_run($sformatf("Fail %s: expected %s, actual %s", name, exp, act));
  endtask

  task automatic check_status(input string name, input uart_status_s exp,
                              input uart_status_s act);
    if (exp !== act)
      value_fail(name, $sformatf("%b", exp), $sformatf("%b", act));
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (exp !== act)
      value_fail(name, $sformatf("%h", exp), $sformatf("%h", act));
  endtask

  task automatic check_rsp(input string name, input apb_rsp_s exp, input apb_rsp_s act);
    // handshake only
    if ({exp.pready, exp.pslverr} !== {act.pready, act.pslverr})
      value_fail(name, $sformatf("pready %b pslverr %b", exp.pready, exp.pslverr),
                 $sformatf("pready %b pslverr %b", act.pready, act.pslverr));
  endtask

  task automatic check_ctrl(input string name, input uart_ctrl_s exp, input uart_ctrl_s act);
    if (exp !== act)
      value_fail(name, $sformatf("%h", exp), $sformatf("%h", act));
  endtask

  task automatic check_cmd(input string name, input cmd_word_u exp, input cmd_word_u act);
    if (exp !== act)
      value_fail(name, $sformatf("%h", exp), $sformatf("%h", act));
  endtask

  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data,
                           output apb_rsp_s rsp);
    @(posedge clk);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(negedge clk);
    rsp = apb_rsp;
    @(posedge clk);
    apb_req <= '0;
  endtask

  task automatic apb_read(input logic [3:0] addr, output apb_rsp_s rsp);
    @(posedge clk);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'd0};
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(negedge clk);
    rsp = apb_rsp;   // access phase
    @(posedge clk);
    apb_req <= '0;
  endtask

  task automatic read_status(output uart_status_s st);
    apb_rsp_s rsp;
    apb_read(reg_status, rsp);
    check_rsp("status read", rsp_ok, rsp);
    st = rsp.prdata[3:0];
  endtask

  task automatic wait_not_busy();
    uart_status_s st;
    do
      read_status(st);
    while (st.busy);
  endtask

  task automatic set_ctrl(input uart_ctrl_s c);
    apb_rsp_s   rsp;
    uart_ctrl_s back;
    apb_write(reg_ctrl, {20'd0, c}, rsp);
    check_rsp("ctrl write", rsp_ok, rsp);
    apb_read(reg_ctrl, rsp);
    back = rsp.prdata[11:0];
    check_ctrl("ctrl readback", c, back);
  endtask

  task automatic run_cmd(input string name, input cmd_word_u cw);
    apb_rsp_s  rsp;
    cmd_word_u back;
    apb_write(reg_cmd, {16'd0, cw}, rsp);
    check_rsp({name, " cmd write"}, rsp_ok, rsp);
    apb_read(reg_cmd, rsp);
    back = rsp.prdata[15:0];
    check_cmd({name, " cmd readback"}, cw, back);
    wait_not_busy();
  endtask

  task automatic check_frame_count(input string name, input int exp);
    if (dev0.bytes_q.size() != exp)
      abort_run($sformatf("%s: peer saw %0d frames, expected %0d", name,
                          dev0.bytes_q.size(), exp));
  endtask

  task automatic check_frame(input string name, input int idx, input logic [7:0] exp);
    check_byte(name, exp, dev0.bytes_q[idx]);
    if (!dev0.par_ok_q[idx])
      abort_run($sformatf("%s: frame %0d has bad parity or framing", name, idx));
  endtask

  task automatic do_write(input string name, input logic [6:0] addr, input logic [7:0] data,
                          input logic [3:0] gap);
    cmd_word_u    cw;
    uart_status_s st;
    int           n0;
    int           spacing;
    n0 = dev0.bytes_q.size();
    cw.fields = '{rw: 1'b1, addr: addr, data: data};
    run_cmd(name, cw);
    check_frame_count(name, n0 + 2);
    check_frame({name, " hi"}, n0, {1'b1, addr});
    check_frame({name, " lo"}, n0 + 1, data);
    spacing = dev0.start_q[n0 + 1] - dev0.start_q[n0] - 11 * baud_div;
    if (spacing < int'(gap) * baud_div)
      abort_run($sformatf("%s: only %0d idle cycles between frames, gap is %0d bits",
                          name, spacing, gap));
    read_status(st);
    check_status({name, " status"}, exp_status(1'b0, 1'b0, 1'b0), st);
  endtask

  task automatic issue_read(input string name, input logic [6:0] addr, input logic [7:0] data);
    cmd_word_u cw;
    int        n0;
    n0 = dev0.bytes_q.size();
    cw.fields = '{rw: 1'b0, addr: addr, data: data};
    run_cmd(name, cw);
    check_frame_count(name, n0 + 1);
    check_frame({name, " hi"}, n0, {1'b0, addr});
  endtask

  task automatic read_and_collect(input string name, input logic [6:0] addr,
                                  input logic [7:0] data);
    uart_status_s st;
    apb_rsp_s     rsp;
    issue_read(name, addr, data);
    read_status(st);
    check_status({name, " status"}, exp_status(1'b1, 1'b0, 1'b0), st);
    apb_read(reg_rdata, rsp);
    check_byte({name, " rdata"}, model_reply(addr), rsp.prdata[7:0]);
    read_status(st);
    check_status({name, " rd_valid clear"}, exp_status(1'b0, 1'b0, 1'b0), st);
  endtask

  initial
  begin : run_tests
    apb_rsp_s     rsp;
    uart_status_s st;
    uart_ctrl_s   c;
    cmd_word_u    cw;
    cmd_word_u    back;
    logic [15:0]  v;
    int           k;
    int           n0;

    apb_req    <= '0;
    rst_n      <= 1'b0;
    bad_parity <= 1'b0;
    silent     <= 1'b0;
    lfsr_state = 16'd58093;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    apb_read(reg_ctrl, rsp);
    c = '{gap_bits: 4'd2, timeout_bits: 8'd40};
    check_ctrl("reset ctrl", c, rsp.prdata[11:0]);
    read_status(st);
    check_status("reset status", exp_status(1'b0, 1'b0, 1'b0), st);
    apb_read(4'h6, rsp);
    check_rsp("unmapped read", rsp_err, rsp);
    apb_write(4'h3, 32'h0000_FFFF, rsp);
    check_rsp("unmapped write", rsp_err, rsp);
    take_bits(12, v);
    c = v[11:0];
    set_ctrl(c);

    for (k = 0; k < 3; k++)
    begin
      take_bits(4, v);
      c = '{gap_bits: v[3:0], timeout_bits: 8'd40};
      set_ctrl(c);
      take_bits(15, v);
      do_write($sformatf("write %0d", k), v[14:8], v[7:0], c.gap_bits);
    end

    c = '{gap_bits: 4'd2, timeout_bits: 8'd40};
    set_ctrl(c);
    for (k = 0; k < 3; k++)
    begin
      take_bits(15, v);
      read_and_collect($sformatf("read %0d", k), v[14:8], v[7:0]);
    end

    bad_parity <= 1'b1;
    issue_read("bad parity", 7'h21, 8'h00);
    read_status(st);
    check_status("bad parity status", exp_status(1'b0, 1'b1, 1'b0), st);
    apb_write(reg_status, 32'h0000_0004, rsp);
    read_status(st);
    check_status("parity clear", exp_status(1'b0, 1'b0, 1'b0), st);
    bad_parity <= 1'b0;

    silent <= 1'b1;
    c = '{gap_bits: 4'd2, timeout_bits: 8'd5};
    set_ctrl(c);
    issue_read("silent peer", 7'h0F, 8'h00);
    read_status(st);
    check_status("silent status", exp_status(1'b0, 1'b0, 1'b1), st);
    apb_write(reg_status, 32'h0000_0008, rsp);
    silent <= 1'b0;
    c = '{gap_bits: 4'd2, timeout_bits: 8'd40};
    set_ctrl(c);
    take_bits(15, v);
    read_and_collect("read after timeout", v[14:8], v[7:0]);

    // second command lands while the first is in flight
    n0 = dev0.bytes_q.size();
    cw.fields = '{rw: 1'b1, addr: 7'h55, data: 8'hC3};
    apb_write(reg_cmd, {16'd0, cw}, rsp);
    check_rsp("busy first cmd", rsp_ok, rsp);
    apb_write(reg_cmd, 32'h0000_1234, rsp);
    check_rsp("busy second cmd", rsp_err, rsp);
    wait_not_busy();
    repeat (12 * baud_div) @(posedge clk);   // room for a stray frame
    check_frame_count("busy write", n0 + 2);
    check_frame("busy hi", n0, {1'b1, 7'h55});
    check_frame("busy lo", n0 + 1, 8'hC3);
    apb_read(reg_cmd, rsp);
    back = rsp.prdata[15:0];
    check_cmd("busy cmd kept", cw, back);

    $display("*** TEST PASSED ***");
    $finish;
  end

  initial
  begin : watchdog
    repeat (watchdog_cycles) @(posedge clk);
    abort_run($sformatf("watchdog: tests not finished after %0d cycles, DUT appears hung",
                        watchdog_cycles));
  end

endmodule

// ==== test/uart_device_model.sv ====
`timescale 1ns/100ps

module uart_device_model
#(
  parameter int baud_div = 434
)
(
  input  logic clk,
  input  logic tx,           // serial out of the dut
  input  logic bad_parity,
  input  logic silent,
  output logic rx
);

  logic [7:0] bytes_q[$];
  logic       par_ok_q[$];   // parity, start and stop all good
  int         start_q[$];    // cycle of the start edge
  int         cyc = 0;

  always @(posedge clk)
    cyc <= cyc + 1;

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic send_frame(input logic [7:0] b, input logic flip);
    logic [10:0] bits;
    int          i;
    bits = {1'b1, (^b) ^ flip, b, 1'b0};
    for (i = 0; i < 11; i++)
    begin
      @(posedge clk);
      rx <= bits[i];
      repeat (baud_div - 1) @(posedge clk);
    end
  endtask

  initial
  begin : decode
    logic [7:0] b;
    logic       p;
    logic       ok;
    logic       want_lo;
    int         t0;
    int         i;
    rx <= 1'b1;
    want_lo = 1'b0;
    forever
    begin
      @(negedge clk);
      if (tx === 1'b0)
      begin
        t0 = cyc;
        wait_cycles(baud_div / 2);   // mid start bit
        ok = (tx === 1'b0);
        for (i = 0; i < 8; i++)
        begin
          wait_cycles(baud_div);
          b[i] = tx;
        end
        wait_cycles(baud_div);
        p = tx;
        wait_cycles(baud_div);
        ok = ok && (p === ^b) && (tx === 1'b1);
        bytes_q.push_back(b);
        par_ok_q.push_back(ok);
        start_q.push_back(t0);
        if (want_lo)
          want_lo = 1'b0;
        else if (b[7])
          want_lo = 1'b1;            // write, data byte follows
        else if (!silent)
        begin
          // end of stop bit, then 3 idle bits
          wait_cycles(baud_div - baud_div / 2 + 3 * baud_div);
          send_frame({1'b0, b[6:0]} ^ 8'h5A, bad_parity);
        end
      end
    end
  end

endmodule

// ==== logic/uart_cmd_top.sv ====
`timescale 1ns/100ps

module uart_cmd_top import uart_cmd_pkg::*;
#(
  parameter int unsigned baud_div = 434
)
(
  input  logic     clk,
  input  logic     rst_n,
  input  apb_req_s apb_req,
  output apb_rsp_s apb_rsp,
  input  logic     rx,
  output logic     tx
);

  uart_ctrl_s  ctrl;
  logic        cmd_start;
  cmd_word_u   cmd_word;
  logic        busy;
  seq_result_s result;
  logic        tx_start;
  logic [7:0]  tx_byte;
  logic        tx_done;
  logic        rx_arm;
  rx_frame_s   rx_frame;

  uart_apb_regs u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .ctrl      (ctrl),
    .cmd_start (cmd_start),
    .cmd_word  (cmd_word),
    .busy      (busy),
    .result    (result)
  );

  uart_cmd_sequencer #(.baud_div(baud_div)) u_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_start (cmd_start),
    .cmd_word  (cmd_word),
    .ctrl      (ctrl),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .tx_done   (tx_done),
    .rx_arm    (rx_arm),
    .rx_frame  (rx_frame),
    .busy      (busy),
    .result    (result)
  );

  uart_tx_frame #(.baud_div(baud_div)) u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_done  (tx_done),
    .tx       (tx)
  );

  uart_rx_frame #(.baud_div(baud_div)) u_rx (
    .clk          (clk),
    .rst_n        (rst_n),
    .rx           (rx),
    .rx_arm       (rx_arm),
    .timeout_bits (ctrl.timeout_bits),
    .rx_frame     (rx_frame)
  );

endmodule

// ==== logic/uart_apb_regs.sv ====
`timescale 1ns/100ps

module uart_apb_regs import uart_cmd_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  apb_req_s    apb_req,
  output apb_rsp_s    apb_rsp,
  output uart_ctrl_s  ctrl,
  output logic        cmd_start,
  output cmd_word_u   cmd_word,
  input  logic        busy,
  input  seq_result_s result
);

  uart_status_s status;
  logic         access;
  logic         wr_acc;
  logic         rd_acc;
  logic         cmd_busy;
  logic         cmd_hit;
  logic         cmd_accept;
  logic         mapped;
  logic         rd_valid;
  logic         parity_err;
  logic         timeout_flag;
  logic [7:0]   rdata_q;

  assign access     = apb_req.psel & apb_req.penable;
  assign wr_acc     = access & apb_req.pwrite;
  assign rd_acc     = access & !apb_req.pwrite;
  assign cmd_busy   = busy | cmd_start;   // covers the launch cycle
  assign cmd_hit    = wr_acc & (apb_req.paddr == reg_cmd);
  assign cmd_accept = cmd_hit & !cmd_busy;

  assign status.busy       = cmd_busy;
  assign status.rd_valid   = rd_valid;
  assign status.parity_err = parity_err;
  assign status.timeout    = timeout_flag;

  always_comb
  begin
    mapped         = 1'b1;
    apb_rsp.prdata = '0;
    case (apb_req.paddr)
      reg_ctrl:   apb_rsp.prdata = {20'd0, ctrl};
      reg_cmd:    apb_rsp.prdata = {16'd0, cmd_word};
      reg_status: apb_rsp.prdata = {28'd0, status};
      reg_rdata:  apb_rsp.prdata = {24'd0, rdata_q};
      default:    mapped = 1'b0;
    endcase
    apb_rsp.pready  = 1'b1;
    apb_rsp.pslverr = access & (!mapped | (cmd_hit & cmd_busy));
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ctrl         <= uart_ctrl_rst;
      cmd_word     <= '0;
      cmd_start    <= 1'b0;
      rd_valid     <= 1'b0;
      parity_err   <= 1'b0;
      timeout_flag <= 1'b0;
      rdata_q      <= '0;
    end
    else
    begin
      cmd_start <= cmd_accept;
      if (cmd_accept)
        cmd_word <= apb_req.pwdata[15:0];
      if (wr_acc && apb_req.paddr == reg_ctrl)
        ctrl <= apb_req.pwdata[11:0];

      // rd_valid tracks the last command, cleared by a data read
      if (result.done)
      begin
        rd_valid <= result.was_read & !result.parity_err & !result.timeout;
        if (result.was_read)
          rdata_q <= result.rdata;
      end
      else if (rd_acc && apb_req.paddr == reg_rdata)
        rd_valid <= 1'b0;

      // sticky errors, write one to clear
      if (result.done && result.parity_err)
        parity_err <= 1'b1;
      else if (wr_acc && apb_req.paddr == reg_status && apb_req.pwdata[2])
        parity_err <= 1'b0;

      if (result.done && result.timeout)
        timeout_flag <= 1'b1;
      else if (wr_acc && apb_req.paddr == reg_status && apb_req.pwdata[3])
        timeout_flag <= 1'b0;
    end
  end

endmodule

// ==== logic/uart_cmd_sequencer.sv ====
`timescale 1ns/100ps

module uart_cmd_sequencer import uart_cmd_pkg::*;
#(
  parameter int unsigned baud_div = 434
)
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        cmd_start,
  input  cmd_word_u   cmd_word,
  input  uart_ctrl_s  ctrl,
  output logic        tx_start,
  output logic [7:0]  tx_byte,
  input  logic        tx_done,
  output logic        rx_arm,
  input  rx_frame_s   rx_frame,
  output logic        busy,
  output seq_result_s result
);

  localparam int cnt_w = $clog2(baud_div);
  localparam logic [cnt_w-1:0] baud_last = cnt_w'(baud_div - 1);

  typedef enum logic [2:0] {
    st_idle,
    st_judge,
    st_send_hi,
    st_gap,
    st_send_lo,
    st_wait_reply,
    st_finish
  } seq_state_e;

  seq_state_e       state;
  cmd_word_u        cmd_q;
  logic [cnt_w-1:0] baud_cnt;
  logic [3:0]       gap_cnt;

  assign busy = (state != st_idle);

  always_ff @(posedge clk)
  begin
    if (state == st_idle && cmd_start)
      cmd_q <= cmd_word;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= st_idle;
      tx_start <= 1'b0;
      tx_byte  <= '0;
      rx_arm   <= 1'b0;
      baud_cnt <= '0;
      gap_cnt  <= '0;
      result   <= '0;
    end
    else
    begin
      tx_start    <= 1'b0;
      rx_arm      <= 1'b0;
      result.done <= 1'b0;
      case (state)
        st_idle:
          if (cmd_start)
            state <= st_judge;
        st_judge:
        begin
          tx_start <= 1'b1;
          tx_byte  <= cmd_q.bytes.hi;
          state    <= st_send_hi;
        end
        st_send_hi:
        begin
          if (tx_done)
          begin
            baud_cnt <= '0;
            gap_cnt  <= '0;
            if (cmd_q.fields.rw)
              state <= st_gap;
            else
            begin
              rx_arm <= 1'b1;   // reply hunt starts after hi frame
              state  <= st_wait_reply;
            end
          end
        end
        st_gap:
        begin
          if (gap_cnt >= ctrl.gap_bits)
          begin
            tx_start <= 1'b1;
            tx_byte  <= cmd_q.bytes.lo;
            state    <= st_send_lo;
          end
          else if (baud_cnt == baud_last)
          begin
            baud_cnt <= '0;
            gap_cnt  <= gap_cnt + 4'd1;
          end
          else
            baud_cnt <= baud_cnt + 1'b1;
        end
        st_send_lo:
        begin
          if (tx_done)
          begin
            result <= '{done: 1'b1, was_read: 1'b0, rdata: 8'd0,
                        parity_err: 1'b0, timeout: 1'b0};
            state  <= st_finish;
          end
        end
        st_wait_reply:
        begin
          if (rx_frame.valid)
          begin
            result <= '{done: 1'b1, was_read: 1'b1, rdata: rx_frame.data,
                        parity_err: rx_frame.parity_err, timeout: 1'b0};
            state  <= st_finish;
          end
          else if (rx_frame.timeout)
          begin
            result <= '{done: 1'b1, was_read: 1'b1, rdata: 8'd0,
                        parity_err: 1'b0, timeout: 1'b1};
            state  <= st_finish;
          end
        end
        st_finish:
          state <= st_idle;   // done visible here, busy drops next
        default:
          state <= st_idle;
      endcase
    end
  end

endmodule

// ==== logic/uart_rx_frame.sv ====
`timescale 1ns/100ps

module uart_rx_frame import uart_cmd_pkg::*;
#(
  parameter int unsigned baud_div = 434
)
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  input  logic       rx_arm,
  input  logic [7:0] timeout_bits,
  output rx_frame_s  rx_frame
);

  localparam int cnt_w = $clog2(baud_div);
  localparam logic [cnt_w-1:0] baud_last = cnt_w'(baud_div - 1);
  localparam logic [cnt_w-1:0] half_load = cnt_w'(baud_div - 1 - baud_div / 2);
  localparam logic [3:0] last_bit = 4'(uart_frame_bits - 1);

  typedef enum logic [1:0] {st_idle, st_hunt, st_bits} rx_state_e;

  rx_state_e        state;
  logic             rx_meta;
  logic             rx_sync;
  logic [cnt_w-1:0] baud_cnt;
  logic [3:0]       bit_cnt;
  logic [7:0]       tmo_cnt;
  logic [7:0]       data_sr;
  logic             par_bit;
  logic             baud_wrap;

  assign baud_wrap = (baud_cnt == baud_last);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= st_idle;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      tmo_cnt  <= '0;
      rx_frame <= '0;
    end
    else
    begin
      rx_frame.valid   <= 1'b0;
      rx_frame.timeout <= 1'b0;
      if (rx_arm)
      begin
        state    <= st_hunt;
        baud_cnt <= '0;
        tmo_cnt  <= '0;
      end
      else
      begin
        case (state)
          st_hunt:
          begin
            if (!rx_sync)
            begin
              state    <= st_bits;
              baud_cnt <= half_load;   // first sample at mid start bit
              bit_cnt  <= '0;
            end
            else if (baud_wrap)
            begin
              baud_cnt <= '0;
              tmo_cnt  <= tmo_cnt + 8'd1;
              if ({1'b0, tmo_cnt} + 9'd1 >= {1'b0, timeout_bits})
              begin
                rx_frame.timeout <= 1'b1;
                state            <= st_idle;
              end
            end
            else
              baud_cnt <= baud_cnt + 1'b1;
          end
          st_bits:
          begin
            if (baud_wrap)
            begin
              baud_cnt <= '0;
              bit_cnt  <= bit_cnt + 4'd1;
              if (bit_cnt == 4'd0 && rx_sync)
                state <= st_hunt;   // glitch, not a start bit
              else if (bit_cnt == last_bit)
              begin
                rx_frame.valid      <= 1'b1;
                rx_frame.data       <= data_sr;
                rx_frame.parity_err <= (^data_sr ^ par_bit) | !rx_sync;
                state               <= st_idle;
              end
            end
            else
              baud_cnt <= baud_cnt + 1'b1;
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == st_bits && baud_wrap)
    begin
      if (bit_cnt >= 4'd1 && bit_cnt <= 4'd8)
        data_sr <= {rx_sync, data_sr[7:1]};   // lsb first
      else if (bit_cnt == 4'd9)
        par_bit <= rx_sync;
    end
  end

endmodule

// ==== logic/uart_tx_frame.sv ====
`timescale 1ns/100ps

module uart_tx_frame import uart_cmd_pkg::*;
#(
  parameter int unsigned baud_div = 434
)
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_start,
  input  logic [7:0] tx_byte,
  output logic       tx_done,
  output logic       tx
);

  localparam int cnt_w = $clog2(baud_div);
  localparam logic [cnt_w-1:0] baud_last = cnt_w'(baud_div - 1);
  localparam logic [3:0] last_bit = 4'(uart_frame_bits - 1);

  logic [10:0]      shreg;
  logic [cnt_w-1:0] baud_cnt;
  logic [3:0]       bit_cnt;
  logic             active;
  logic             baud_wrap;

  assign baud_wrap = active && (baud_cnt == baud_last);
  assign tx_done   = baud_wrap && (bit_cnt == last_bit);
  assign tx        = shreg[0];   // idles high, refilled with ones

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      shreg    <= '1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      active   <= 1'b0;
    end
    else if (tx_start)
    begin
      // stop, even parity, data lsb first, start
      shreg    <= {1'b1, ^tx_byte, tx_byte, 1'b0};
      baud_cnt <= '0;
      bit_cnt  <= '0;
      active   <= 1'b1;
    end
    else if (baud_wrap)
    begin
      shreg    <= {1'b1, shreg[10:1]};
      baud_cnt <= '0;
      bit_cnt  <= bit_cnt + 4'd1;
      if (bit_cnt == last_bit)
        active <= 1'b0;
    end
    else if (active)
    begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

endmodule

// ==== logic/uart_cmd_pkg.sv ====
package uart_cmd_pkg;

  // start + 8 data + parity + stop
  localparam int uart_frame_bits = 11;

  typedef struct packed {
    logic [7:0] hi;
    logic [7:0] lo;
  } cmd_bytes_s;

  typedef struct packed {
    logic       rw;   // 1 = write
    logic [6:0] addr;
    logic [7:0] data;
  } cmd_fields_s;

  typedef union packed {
    cmd_bytes_s  bytes;
    cmd_fields_s fields;
  } cmd_word_u;

  typedef struct packed {
    logic [3:0] gap_bits;
    logic [7:0] timeout_bits;
  } uart_ctrl_s;

  localparam uart_ctrl_s uart_ctrl_rst = '{gap_bits: 4'd2, timeout_bits: 8'd40};

  // bit 0 busy .. bit 3 timeout
  typedef struct packed {
    logic timeout;
    logic parity_err;
    logic rd_valid;
    logic busy;
  } uart_status_s;

  typedef struct packed {
    logic       done;
    logic       was_read;
    logic [7:0] rdata;
    logic       parity_err;
    logic       timeout;
  } seq_result_s;

  typedef struct packed {
    logic       valid;
    logic [7:0] data;
    logic       parity_err;   // bad stop bit too
    logic       timeout;
  } rx_frame_s;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_s;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_s;

  localparam logic [3:0] reg_ctrl   = 4'h0;
  localparam logic [3:0] reg_cmd    = 4'h4;
  localparam logic [3:0] reg_status = 4'h8;
  localparam logic [3:0] reg_rdata  = 4'hC;

endpackage
